//--- list.f
hw/qsnd_pkg.sv
hw/z80_bus_decode.sv
hw/qsnd_mailbox.sv
hw/z80_int_timer.sv
hw/dsp_sample_capture.sv
hw/qsnd_frame_pacer.sv
hw/volume_ctrl.sv
hw/qsnd_sound_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Bender.yml
package:
  name: qsnd_sound

sources:
  - hw/qsnd_pkg.sv
  - hw/z80_bus_decode.sv
  - hw/qsnd_mailbox.sv
  - hw/z80_int_timer.sv
  - hw/dsp_sample_capture.sv
  - hw/qsnd_frame_pacer.sv
  - hw/volume_ctrl.sv
  - hw/qsnd_sound_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_checker.sv
      - tests/tb_top.sv

//--- tests/tb_top.sv
/* testbench top for the QSound glue: drives the Z80 bus from an access table,
   then runs mailbox, sample, volume and interrupt sequences; tb_checker compares */
`default_nettype none

module tb_top;
    import qsnd_pkg::*;

    localparam int sig_cpu_din = 0;
    localparam int sig_rom_cs  = 1;
    localparam int sig_rom_addr = 2;
    localparam int sig_ram_cs  = 3;
    localparam int sig_dsp_irq = 4;
    localparam int sig_dsp_rst = 5;
    localparam int sig_pbus    = 6;
    localparam int sig_int_n   = 7;
    localparam int sig_volume  = 8;
    localparam int sig_frame   = 9;
    localparam int sig_sample  = 10;
    localparam int sig_dsp_cen = 11;
    localparam int sig_qaddr   = 12;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd_n;
        logic        wr_n;
        logic        rom_cs;
        logic        ram_cs;
        logic [18:0] rom_addr;
        logic [7:0]  cpu_din;
        logic        dsp_rst;
    } bus_entry_t;

    logic clk48;
    logic rst;
    logic cen8;
    logic vol_up;
    logic vol_down;
    logic qsnd_ok;
    logic [7:0] rom_data;
    logic [7:0] ram_data;
    z80_bus_t   z80;
    dsp_port_t  dsp;
    logic [7:0]         cpu_din;
    logic               int_n;
    logic               rom_cs;
    logic [rom_aw-1:0]  rom_addr;
    logic               ram_cs;
    logic [15:0]        dsp_pbus_in;
    logic               dsp_irq;
    logic               dsp_rst;
    logic               dsp_cen;
    logic [qaddr_w-1:0] qsnd_addr;
    logic [vol_w-1:0]   volume;
    stereo_t            frame;
    logic               sample;

    logic [12:0]       chk_en;
    logic [12:0][31:0] chk_exp;
    int                err_count;
    int                check_count;
    int                timeouts;
    logic [31:0]       lcg_state;
    int                vol_idx;
    bus_entry_t        access_q[$];

    tb_clock u_clock (.clk48(clk48), .rst(rst));

    qsnd_sound_top u_dut (
        .clk48(clk48), .rst(rst), .cen8(cen8), .vol_up(vol_up), .vol_down(vol_down),
        .z80(z80), .cpu_din(cpu_din), .int_n(int_n), .rom_cs(rom_cs),
        .rom_addr(rom_addr), .rom_data(rom_data), .ram_cs(ram_cs), .ram_data(ram_data),
        .dsp(dsp), .dsp_pbus_in(dsp_pbus_in), .dsp_irq(dsp_irq), .dsp_rst(dsp_rst),
        .dsp_cen(dsp_cen), .qsnd_addr(qsnd_addr), .qsnd_ok(qsnd_ok), .volume(volume),
        .frame(frame), .sample(sample)
    );

    tb_checker u_checker (
        .clk48(clk48), .rst(rst), .chk_en(chk_en), .chk_exp(chk_exp),
        .cpu_din(cpu_din), .rom_cs(rom_cs), .rom_addr(rom_addr), .ram_cs(ram_cs),
        .dsp_irq(dsp_irq), .dsp_rst(dsp_rst), .dsp_pbus_in(dsp_pbus_in), .int_n(int_n),
        .volume(volume), .frame(frame), .sample(sample), .dsp_cen(dsp_cen),
        .qsnd_addr(qsnd_addr), .err_count(err_count), .check_count(check_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_rand(output logic [15:0] v);
        lcg_state = lcg_next(lcg_state);
        v = lcg_state[23:8];
    endtask

    // coarse level per group of five steps, fine level within the group
    function automatic logic [12:0] vol_table(input int idx);
        logic [12:0] coarse;
        logic [12:0] fine;
        case (idx / 5)
            0: coarse = 13'h1000;
            1: coarse = 13'h0800;
            2: coarse = 13'h0400;
            3: coarse = 13'h0200;
            4: coarse = 13'h0100;
            5: coarse = 13'h0080;
            6: coarse = 13'h0040;
            default: coarse = 13'h0020;
        endcase
        case (idx % 5)
            0: fine = 13'h10;
            1: fine = 13'h08;
            2: fine = 13'h04;
            3: fine = 13'h02;
            default: fine = 13'h01;
        endcase
        return coarse | fine;
    endfunction

    task automatic add_access(input logic [15:0] addr, input logic [7:0] data,
                              input logic rd_n, input logic wr_n, input logic rcs,
                              input logic mcs, input logic [18:0] raddr,
                              input logic [7:0] din, input logic drst);
        access_q.push_back({addr, data, rd_n, wr_n, rcs, mcs, raddr, din, drst});
    endtask

    // one rising edge for the checker, then back to the falling edge
    task automatic tick;
        @(posedge clk48);
        @(negedge clk48);
        chk_en = '0;
    endtask

    task automatic set_expect(input int idx, input logic [31:0] val);
        chk_en[idx]  = 1'b1;
        chk_exp[idx] = val;
    endtask

    task automatic bus_idle;
        z80 = '{addr: 16'h0, dout: 8'h0, mreq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1,
                m1_n: 1'b1, iorq_n: 1'b1};
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        z80.addr   = addr;
        z80.dout   = data;
        z80.mreq_n = 1'b0;
        z80.wr_n   = 1'b0;
        tick;
        bus_idle;
    endtask

    task automatic wait_sample;
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 2 * frame_period) begin
            tick;
            n++;
            if (sample)
                seen = 1'b1;
        end
        if (!seen) begin
            $display("timeout: no sample pulse within %0d cycles", 2 * frame_period);
            timeouts++;
        end
    endtask

    task automatic press(input logic up);
        if (up) begin
            vol_up = 1'b1;
            if (vol_idx < 39)
                vol_idx++;
        end else begin
            vol_down = 1'b1;
            if (vol_idx > 0)
                vol_idx--;
        end
        tick;
        tick;
        set_expect(sig_volume, 32'(vol_table(vol_idx)));
        vol_up   = 1'b0;
        vol_down = 1'b0;
        tick;
    endtask

    initial begin
        bus_entry_t  e;
        logic [15:0] hi_lo;
        logic [15:0] a_byte;
        logic [15:0] left;
        logic [15:0] right;
        logic [15:0] lo_word;
        logic [15:0] hi_word;
        int          n;

        cen8      = 1'b0;
        vol_up    = 1'b0;
        vol_down  = 1'b0;
        qsnd_ok   = 1'b1;
        rom_data  = 8'ha5;
        ram_data  = 8'h3c;
        dsp       = '0;
        dsp.pids_n = 1'b1;
        dsp.pods_n = 1'b1;
        chk_en    = '0;
        chk_exp   = '0;
        timeouts  = 0;
        lcg_state = 32'd23620;
        vol_idx   = 39;
        bus_idle;

        //         addr      data   rd wr rom ram rom_addr   din    rst
        add_access(16'h1234, 8'h00, 0, 1, 1, 0, 19'h01234, 8'ha5, 1);
        add_access(16'hd003, 8'h85, 1, 0, 0, 0, 19'h00000, 8'hff, 1);
        add_access(16'h8010, 8'h00, 0, 1, 1, 0, 19'h1c010, 8'ha5, 0);
        add_access(16'hbfff, 8'h00, 0, 1, 1, 0, 19'h1ffff, 8'ha5, 0);
        add_access(16'hc100, 8'h00, 0, 1, 0, 1, 19'h00000, 8'h3c, 0);
        add_access(16'hf0ff, 8'h00, 0, 1, 0, 1, 19'h00000, 8'h3c, 0);
        add_access(16'hd007, 8'h00, 0, 1, 0, 0, 19'h00000, 8'hf5, 0);
        add_access(16'he000, 8'h00, 0, 1, 0, 0, 19'h00000, 8'hff, 0);
        add_access(16'hd003, 8'h0a, 1, 0, 0, 0, 19'h00000, 8'hff, 0);
        add_access(16'h9000, 8'h00, 0, 1, 1, 0, 19'h31000, 8'ha5, 1);
        add_access(16'hd007, 8'h00, 0, 1, 0, 0, 19'h00000, 8'hfa, 1);
        add_access(16'hd005, 8'h00, 0, 1, 0, 0, 19'h00000, 8'hff, 1);

        // reset values, checked while rst is still high
        @(negedge clk48);
        set_expect(sig_int_n, 1);
        set_expect(sig_dsp_rst, 1);
        set_expect(sig_dsp_irq, 0);
        set_expect(sig_volume, 0);
        set_expect(sig_sample, 0);
        set_expect(sig_dsp_cen, 1);
        n = 0;
        while (rst && n < 10) begin
            tick;
            n++;
        end
        if (rst) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
        tick;

        foreach (access_q[k]) begin
            e = access_q[k];
            z80.addr   = e.addr;
            z80.dout   = e.data;
            z80.mreq_n = 1'b0;
            z80.rd_n   = e.rd_n;
            z80.wr_n   = e.wr_n;
            set_expect(sig_rom_cs, 32'(e.rom_cs));
            set_expect(sig_ram_cs, 32'(e.ram_cs));
            set_expect(sig_cpu_din, 32'(e.cpu_din));
            set_expect(sig_dsp_rst, 32'(e.dsp_rst));
            if (e.rom_cs)
                set_expect(sig_rom_addr, 32'(e.rom_addr));
            tick;
        end
        bus_idle;
        tick;

        // mailbox, bank is 0a from the table
        repeat (2) begin
            next_rand(hi_lo);
            next_rand(a_byte);
            bus_write(16'hd000, hi_lo[15:8]);
            bus_write(16'hd001, hi_lo[7:0]);
            bus_write(16'hd002, a_byte[7:0]);
            z80.addr   = 16'hd007;
            z80.mreq_n = 1'b0;
            z80.rd_n   = 1'b0;
            set_expect(sig_dsp_irq, 1);
            set_expect(sig_pbus, {24'h0, a_byte[7:0]});
            set_expect(sig_cpu_din, 32'h7a);   // ready bit low while irq pending
            tick;
            bus_idle;
            dsp.pids_n = 1'b0;
            tick;
            dsp.pids_n = 1'b1;
            tick;
            set_expect(sig_dsp_irq, 0);
            set_expect(sig_pbus, 32'(hi_lo));
            tick;
        end

        // sample ROM address, low half on pods_n rise, high bits from ab
        repeat (2) begin
            next_rand(lo_word);
            next_rand(hi_word);
            dsp.pbus_out = lo_word;
            dsp.pods_n   = 1'b0;
            dsp.ab       = {1'b1, 8'h00, hi_word[6:0]};
            dsp.cen_cko  = 1'b1;
            tick;
            dsp.pods_n  = 1'b1;
            dsp.ab      = '0;
            dsp.cen_cko = 1'b0;
            repeat (2) tick;
            set_expect(sig_qaddr, 32'({hi_word[6:0], lo_word}));
            tick;
        end

        // qsnd_ok low stalls the DSP clock enable
        qsnd_ok = 1'b0;
        tick;
        set_expect(sig_dsp_cen, 0);
        qsnd_ok = 1'b1;
        tick;
        set_expect(sig_dsp_cen, 1);
        tick;

        // psel parked high so the only rise is the one closing each pre-frame
        dsp.psel = 1'b1;

        // right word, left word, then psel rise closes the pre-frame
        repeat (2) begin
            wait_sample;
            next_rand(left);
            next_rand(right);
            dsp.psel   = 1'b1;
            dsp.serout = right;
            dsp.sadd   = 1'b1;
            repeat (2) tick;
            dsp.sadd = 1'b0;
            repeat (2) tick;
            dsp.psel   = 1'b0;
            dsp.serout = left;
            dsp.sadd   = 1'b1;
            repeat (2) tick;
            dsp.sadd = 1'b0;
            repeat (2) tick;
            dsp.psel = 1'b1;
            repeat (4) tick;
            set_expect(sig_dsp_cen, 0);
            tick;
            wait_sample;
            set_expect(sig_frame, {left, right});
            set_expect(sig_sample, 1);
            tick;
            set_expect(sig_dsp_cen, 1);
            tick;
        end

        repeat (2) press(1'b1);
        repeat (42) press(1'b0);
        repeat (3) press(1'b1);

        // one pulse short of the interrupt period, then the last pulse
        cen8 = 1'b1;
        repeat (int_period - 1) tick;
        cen8 = 1'b0;
        set_expect(sig_int_n, 1);
        tick;
        cen8 = 1'b1;
        tick;
        cen8 = 1'b0;
        set_expect(sig_int_n, 0);
        tick;
        z80.m1_n   = 1'b0;
        z80.iorq_n = 1'b0;
        cen8       = 1'b1;
        tick;
        cen8 = 1'b0;
        bus_idle;
        set_expect(sig_int_n, 1);
        tick;

        repeat (4) tick;
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_checker.sv
/* compares DUT outputs against the expected values posted by the stimulus
   on every rising edge, and checks the spacing of sample pulses */
`default_nettype none

module tb_checker (
    input  logic              clk48,
    input  logic              rst,
    input  logic [12:0]       chk_en,
    input  logic [12:0][31:0] chk_exp,
    input  logic [7:0]        cpu_din,
    input  logic              rom_cs,
    input  logic [18:0]       rom_addr,
    input  logic              ram_cs,
    input  logic              dsp_irq,
    input  logic              dsp_rst,
    input  logic [15:0]       dsp_pbus_in,
    input  logic              int_n,
    input  logic [12:0]       volume,
    input  qsnd_pkg::stereo_t frame,
    input  logic              sample,
    input  logic              dsp_cen,
    input  logic [22:0]       qsnd_addr,
    output int                err_count,
    output int                check_count
);
    logic [12:0][31:0] act;
    int                i;
    int                since_sample;
    logic              seen_sample;

    assign act[0]  = 32'(cpu_din);
    assign act[1]  = 32'(rom_cs);
    assign act[2]  = 32'(rom_addr);
    assign act[3]  = 32'(ram_cs);
    assign act[4]  = 32'(dsp_irq);
    assign act[5]  = 32'(dsp_rst);
    assign act[6]  = 32'(dsp_pbus_in);
    assign act[7]  = 32'(int_n);
    assign act[8]  = 32'(volume);
    assign act[9]  = frame;          // left in the upper half
    assign act[10] = 32'(sample);
    assign act[11] = 32'(dsp_cen);
    assign act[12] = 32'(qsnd_addr);

    function automatic string sig_name(input int idx);
        case (idx)
            0:       return "cpu_din";
            1:       return "rom_cs";
            2:       return "rom_addr";
            3:       return "ram_cs";
            4:       return "dsp_irq";
            5:       return "dsp_rst";
            6:       return "dsp_pbus_in";
            7:       return "int_n";
            8:       return "volume";
            9:       return "frame";
            10:      return "sample";
            11:      return "dsp_cen";
            default: return "qsnd_addr";
        endcase
    endfunction

    initial begin
        err_count    = 0;
        check_count  = 0;
        since_sample = 0;
        seen_sample  = 1'b0;
    end

    always @(posedge clk48) begin
        for (i = 0; i < 13; i++) begin
            if (chk_en[i]) begin
                check_count++;
                if (act[i] !== chk_exp[i]) begin
                    err_count++;
                    $display("ERR t=%0t %s exp=%h got=%h", $time, sig_name(i),
                             chk_exp[i], act[i]);
                end
            end
        end
        // sample pulses must come exactly 2000 cycles apart
        if (rst) begin
            since_sample = 0;
            seen_sample  = 1'b0;
        end else begin
            since_sample++;
            if (sample) begin
                check_count++;
                if (seen_sample && since_sample != 2000) begin
                    err_count++;
                    $display("ERR t=%0t sample_period exp=%0d got=%0d", $time, 2000,
                             since_sample);
                end
                seen_sample  = 1'b1;
                since_sample = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
/* clock and reset source for the testbench
   clk48 with an 8 unit period, rst held high for the first two cycles */
`default_nettype none

module tb_clock (
    output logic clk48,
    output logic rst
);
    initial begin
        clk48 = 1'b0;
        forever #4 clk48 = ~clk48;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
        rst = 1'b0;   // released on a falling edge
    end

endmodule

`default_nettype wire

//--- hw/qsnd_sound_top.sv
/* QSound sound board glue, Z80 and DSP cores connect through the ports
   bus decode feeds the mailbox, DSP samples go through capture and pacer */
`default_nettype none

module qsnd_sound_top (
    input  logic                         clk48,
    input  logic                         rst,
    input  logic                         cen8,
    input  logic                         vol_up,
    input  logic                         vol_down,
    input  qsnd_pkg::z80_bus_t           z80,
    output logic [7:0]                   cpu_din,
    output logic                         int_n,
    output logic                         rom_cs,
    output logic [qsnd_pkg::rom_aw-1:0]  rom_addr,
    input  logic [7:0]                   rom_data,
    output logic                         ram_cs,
    input  logic [7:0]                   ram_data,
    input  qsnd_pkg::dsp_port_t          dsp,
    output logic [15:0]                  dsp_pbus_in,
    output logic                         dsp_irq,
    output logic                         dsp_rst,
    output logic                         dsp_cen,
    output logic [qsnd_pkg::qaddr_w-1:0] qsnd_addr,
    input  logic                         qsnd_ok,
    output logic [qsnd_pkg::vol_w-1:0]   volume,
    output qsnd_pkg::stereo_t            frame,
    output logic                         sample
);
    import qsnd_pkg::*;

    mem_region_e region;
    logic [3:0]  bank;
    logic        dsp_rdy_n;
    stereo_t     pre_frame;
    logic        base_sample;

    z80_bus_decode u_decode (
        .z80       (z80),
        .bank      (bank),
        .dsp_rdy_n (dsp_rdy_n),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .region    (region),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .ram_cs    (ram_cs),
        .cpu_din   (cpu_din)
    );

    qsnd_mailbox u_mailbox (
        .clk48       (clk48),
        .rst         (rst),
        .region      (region),
        .wdata       (z80.dout),
        .addr_lo     (z80.addr[1:0]),
        .pids_n      (dsp.pids_n),
        .iack        (dsp.iack),
        .bank        (bank),
        .dsp_rst     (dsp_rst),
        .dsp_irq     (dsp_irq),
        .dsp_rdy_n   (dsp_rdy_n),
        .dsp_pbus_in (dsp_pbus_in)
    );

    z80_int_timer u_int_timer (
        .clk48  (clk48),
        .rst    (rst),
        .cen8   (cen8),
        .m1_n   (z80.m1_n),
        .iorq_n (z80.iorq_n),
        .int_n  (int_n)
    );

    dsp_sample_capture u_capture (
        .clk48       (clk48),
        .rst         (rst),
        .dsp         (dsp),
        .pre_frame   (pre_frame),
        .base_sample (base_sample),
        .qsnd_addr   (qsnd_addr)
    );

    qsnd_frame_pacer u_pacer (
        .clk48       (clk48),
        .rst         (rst),
        .pre_frame   (pre_frame),
        .base_sample (base_sample),
        .qsnd_ok     (qsnd_ok),
        .frame       (frame),
        .sample      (sample),
        .dsp_cen     (dsp_cen)
    );

    volume_ctrl u_volume (
        .clk48    (clk48),
        .rst      (rst),
        .vol_up   (vol_up),
        .vol_down (vol_down),
        .volume   (volume)
    );

endmodule

`default_nettype wire

//--- hw/volume_ctrl.sv
/* stepped volume control, vol_up and vol_down rising edges move a saturating
   index and the registered volume word follows from the step table */
`default_nettype none

module volume_ctrl (
    input  logic                       clk48,
    input  logic                       rst,
    input  logic                       vol_up,
    input  logic                       vol_down,
    output logic [qsnd_pkg::vol_w-1:0] volume
);
    import qsnd_pkg::*;

    logic [vol_idx_w-1:0] vol_idx;
    logic                 last_up;
    logic                 last_down;

    // groups of five, coarse part halves per group, fine part halves per step
    function automatic logic [vol_w-1:0] vol_word(input logic [vol_idx_w-1:0] idx);
        logic [vol_w-1:0] coarse;
        logic [vol_w-1:0] fine;
        coarse = 13'h1000 >> (idx / 5);
        fine   = 13'h0010 >> (idx % 5);
        return coarse | fine;
    endfunction

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            vol_idx   <= vol_idx_w'(vol_max_idx);
            last_up   <= 1'b0;
            last_down <= 1'b0;
            volume    <= '0;
        end else begin
            last_up   <= vol_up;
            last_down <= vol_down;
            if (vol_up && !last_up) begin
                if (vol_idx < vol_idx_w'(vol_max_idx))
                    vol_idx <= vol_idx + 1'b1;
            end else if (vol_down && !last_down) begin
                if (vol_idx != '0)
                    vol_idx <= vol_idx - 1'b1;
            end
            volume <= vol_word(vol_idx);   // one cycle behind the index
        end
    end

endmodule

`default_nettype wire

//--- hw/qsnd_frame_pacer.sv
/* emits one stereo frame every frame_period cycles and holds the DSP
   clock enable low from a finished pre-frame until the next period starts */
`default_nettype none

module qsnd_frame_pacer (
    input  logic              clk48,
    input  logic              rst,
    input  qsnd_pkg::stereo_t pre_frame,
    input  logic              base_sample,
    input  logic              qsnd_ok,
    output qsnd_pkg::stereo_t frame,
    output logic              sample,
    output logic              dsp_cen
);
    import qsnd_pkg::*;

    logic [frame_cnt_w-1:0] cnt;
    logic                   sleep;
    logic                   wrap;

    assign wrap = (cnt == frame_cnt_w'(frame_period - 1));

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            sleep   <= 1'b0;
            sample  <= 1'b0;
            dsp_cen <= 1'b1;
            frame   <= '0;
        end else begin
            dsp_cen <= ~sleep & qsnd_ok;   // also stalls while sample ROM data is late
            sample  <= wrap;
            if (wrap) begin
                cnt   <= '0;
                sleep <= 1'b0;
                frame <= pre_frame;
            end else begin
                cnt <= cnt + 1'b1;
                if (base_sample)
                    sleep <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/dsp_sample_capture.sv
/* collects left and right words from the DSP serial port strobes into a pre-frame
   and assembles the QSound sample ROM address from the two DSP address halves */
`default_nettype none

module dsp_sample_capture (
    input  logic                 clk48,
    input  logic                 rst,
    input  qsnd_pkg::dsp_port_t  dsp,
    output qsnd_pkg::stereo_t    pre_frame,
    output logic                 base_sample,
    output logic [qsnd_pkg::qaddr_w-1:0] qsnd_addr
);
    import qsnd_pkg::*;

    dsp_port_t                  dsp_q;    // input register, edges are seen on this copy
    logic                       last_sadd;
    logic                       last_psel;
    logic                       last_pods_n;
    logic signed [sample_w-1:0] reg_left;
    logic signed [sample_w-1:0] reg_right;

    always_ff @(posedge clk48) begin
        dsp_q <= dsp;
        if (!dsp_q.sadd && last_sadd) begin
            if (!dsp_q.psel)
                reg_left <= dsp_q.serout;
            else
                reg_right <= dsp_q.serout;
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd   <= 1'b0;
            last_psel   <= 1'b0;
            last_pods_n <= 1'b1;
            base_sample <= 1'b0;
            pre_frame   <= '0;
            qsnd_addr   <= '0;
        end else begin
            last_sadd   <= dsp_q.sadd;
            last_psel   <= dsp_q.psel;
            last_pods_n <= dsp_q.pods_n;
            base_sample <= dsp_q.psel && !last_psel;
            if (dsp_q.psel && !last_psel) begin
                pre_frame.left  <= reg_left;
                pre_frame.right <= reg_right;
            end
            if (dsp_q.pods_n && !last_pods_n)
                qsnd_addr[15:0] <= dsp_q.pbus_out;
            if (dsp_q.ab[15] && dsp_q.cen_cko)
                qsnd_addr[22:16] <= dsp_q.ab[6:0];   // upper bits from the address bus
        end
    end

endmodule

`default_nettype wire

//--- hw/z80_int_timer.sv
/* periodic Z80 interrupt, one every int_period cen8 pulses
   int_n stays low until the CPU runs an acknowledge cycle */
`default_nettype none

module z80_int_timer (
    input  logic clk48,
    input  logic rst,
    input  logic cen8,
    input  logic m1_n,
    input  logic iorq_n,
    output logic int_n
);
    import qsnd_pkg::*;

    logic [int_cnt_w-1:0] cnt;
    logic                 wrap;

    assign wrap = (cnt == int_cnt_w'(int_period - 1));

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;   // acknowledge wins
            else if (wrap)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/qsnd_mailbox.sv
/* bank register, DSP reset bit and the three-byte CPU to DSP mailbox
   the address byte write raises the DSP interrupt, pids_n rises step the read phase */
`default_nettype none

module qsnd_mailbox (
    input  logic                  clk48,
    input  logic                  rst,
    input  qsnd_pkg::mem_region_e region,
    input  logic [7:0]            wdata,
    input  logic [1:0]            addr_lo,
    input  logic                  pids_n,
    input  logic                  iack,
    output logic [3:0]            bank,
    output logic                  dsp_rst,
    output logic                  dsp_irq,
    output logic                  dsp_rdy_n,
    output logic [15:0]           dsp_pbus_in
);
    import qsnd_pkg::*;

    logic [23:0] mbox;     // address byte on top, data word below
    mbox_phase_e phase;
    logic        last_pids_n;
    logic        pids_rise;

    assign pids_rise = pids_n && !last_pids_n;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank        <= 4'd0;
            dsp_rst     <= 1'b1;
            dsp_irq     <= 1'b0;
            phase       <= phase_idle;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= pids_n;
            if (region == region_bank_wr) begin
                bank    <= wdata[3:0];
                dsp_rst <= ~wdata[7];
            end
            if (region == region_qsnd_wr && addr_lo == 2'd2) begin
                dsp_irq <= 1'b1;
                phase   <= phase_addr;
            end else if (pids_rise) begin
                dsp_irq <= 1'b0;
                case (phase)
                    phase_addr: phase <= phase_data;
                    default:    phase <= phase_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (region == region_qsnd_wr) begin
            case (addr_lo)
                2'd0:    mbox[15:8]  <= wdata;   // data high
                2'd1:    mbox[7:0]   <= wdata;   // data low
                2'd2:    mbox[23:16] <= wdata;   // address
                default: ;
            endcase
        end
    end

    assign dsp_pbus_in = (phase == phase_addr) ? {8'd0, mbox[23:16]} : mbox[15:0];
    assign dsp_rdy_n   = ~(dsp_irq | iack);

endmodule

`default_nettype wire

//--- hw/z80_bus_decode.sv
/* Z80 address decode: classifies each access, forms the banked ROM address
   and muxes the read data back to the CPU; purely combinational */
`default_nettype none

module z80_bus_decode (
    input  qsnd_pkg::z80_bus_t    z80,
    input  logic [3:0]            bank,
    input  logic                  dsp_rdy_n,
    input  logic [7:0]            rom_data,
    input  logic [7:0]            ram_data,
    output qsnd_pkg::mem_region_e region,
    output logic                  rom_cs,
    output logic [qsnd_pkg::rom_aw-1:0] rom_addr,
    output logic                  ram_cs,
    output logic [7:0]            cpu_din
);
    import qsnd_pkg::*;

    logic [3:0] page;
    logic [2:0] offset;

    assign page   = z80.addr[15:12];
    assign offset = z80.addr[2:0];

    always_comb begin
        region = region_none;
        if (!z80.mreq_n) begin
            if (!z80.addr[15]) begin
                region = region_rom_fixed;
            end else if (z80.addr[15:14] == 2'b10) begin
                region = region_rom_bank;   // 8000-BFFF window
            end else if (page == 4'hc || page == 4'hf) begin
                region = region_ram;
            end else if (page == 4'hd) begin
                if (!z80.wr_n && offset <= 3'd2)
                    region = region_qsnd_wr;
                else if (!z80.wr_n && offset == 3'd3)
                    region = region_bank_wr;
                else if (!z80.rd_n && offset == 3'd7)
                    region = region_status_rd;
            end
        end
    end

    assign rom_cs = (region == region_rom_fixed) || (region == region_rom_bank);
    assign ram_cs = (region == region_ram);

    // 16 kB pages placed after the fixed 32 kB
    assign rom_addr = z80.addr[15] ? ({1'b0, bank, z80.addr[13:0]} + bank_base)
                                   : {4'd0, z80.addr[14:0]};

    always_comb begin
        case (region)
            region_rom_fixed,
            region_rom_bank:  cpu_din = rom_data;
            region_ram:       cpu_din = ram_data;
            region_status_rd: cpu_din = {dsp_rdy_n, 3'b111, bank};
            default:          cpu_din = 8'hff;   // open bus
        endcase
    end

endmodule

`default_nettype wire

//--- hw/qsnd_pkg.sv
/* shared widths, address constants, bus structs and enums for the QSound glue logic
   modules import it inside their bodies and use scoped names in their port lists */
`default_nettype none

package qsnd_pkg;

    localparam int rom_aw       = 19;      // program ROM, 512 kB
    localparam int qaddr_w      = 23;      // sample ROM, up to 8 MB
    localparam int sample_w     = 16;
    localparam int vol_w        = 13;
    localparam int vol_steps    = 40;
    localparam int vol_max_idx  = 39;
    localparam int vol_idx_w    = $clog2(vol_steps);
    localparam logic [rom_aw-1:0] bank_base = 19'h08000;
    localparam int frame_period = 2000;    // clk48 cycles per stereo frame
    localparam int frame_cnt_w  = $clog2(frame_period);
    localparam int int_period   = 32000;   // cen8 pulses per Z80 interrupt
    localparam int int_cnt_w    = $clog2(int_period);

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } z80_bus_t;

    typedef struct packed {
        logic [15:0] pbus_out;
        logic [15:0] ab;
        logic [15:0] serout;   // parallel copy of the serial output word
        logic        pods_n;
        logic        pids_n;
        logic        sadd;
        logic        psel;     // low for left, high for right
        logic        cen_cko;
        logic        iack;
    } dsp_port_t;

    typedef struct packed {
        logic signed [sample_w-1:0] left;
        logic signed [sample_w-1:0] right;
    } stereo_t;

    typedef enum logic [2:0] {
        region_none,
        region_rom_fixed,
        region_rom_bank,
        region_ram,
        region_qsnd_wr,
        region_bank_wr,
        region_status_rd
    } mem_region_e;

    typedef enum logic [1:0] {
        phase_idle,
        phase_addr,
        phase_data
    } mbox_phase_e;

endpackage

`default_nettype wire
